// File: acq_pkg.sv
package acq_pkg;

////////////////////////////////////////////////////////////////////////////
// sample format
////////////////////////////////////////////////////////////////////////////

localparam int unsigned SMP_W = 14;  // adc resolution

// two's complement adc sample
typedef logic signed [SMP_W-1:0] smp_t;

// one stream beat
typedef struct packed {
  smp_t dat;  // sample value
  logic lst;  // end of frame
} str_t;

////////////////////////////////////////////////////////////////////////////
// trigger sources
////////////////////////////////////////////////////////////////////////////

localparam int unsigned TRG_N = 2;  // number of trigger sources

localparam int unsigned TRG_SW  = 0;  // software trigger bit
localparam int unsigned TRG_LVL = 1;  // level crossing bit

// slope of level crossing
typedef enum logic {
  EDGE_RISE = 1'b0,  // below -> at/above
  EDGE_FALL = 1'b1   // above -> at/below
} trg_edge_t;

////////////////////////////////////////////////////////////////////////////
// acquisition controller
////////////////////////////////////////////////////////////////////////////

typedef enum logic [1:0] {
  ACQ_IDLE = 2'd0,  // stopped
  ACQ_PRE  = 2'd1,  // armed, waiting for trigger
  ACQ_PST  = 2'd2   // triggered, post samples
} acq_state_t;

endpackage: acq_pkg

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the scope capture testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
  --top-module scope_tb \
  -f verilog.f

out="$(./obj_dir/Vscope_tb 2>&1)" || true
printf '%s\n' "$out"

if grep -q "TESTS PASSED" <<< "$out"; then
  exit 0
fi
exit 1

// File: scope_acq.sv
`timescale 1ns/100ps

module scope_acq #(
  int unsigned TW = 32,  // time stamp width
  int unsigned CW = 16   // counter width
)(
  input  logic                      sti,      // sample clock
  input  logic                      ctl_rst,  // sync reset / clear acq
  // input stream
  input  acq_pkg::str_t             s_str,
  input  logic                      s_vld,
  output logic                      s_rdy,
  output logic                      s_trn,    // transfer strobe, to trigger
  // free running time
  input  logic [TW-1:0]             cts,
  // trigger sources and mode
  input  logic                      lvl_trg,  // level crossing pulse
  input  logic [acq_pkg::TRG_N-1:0] cfg_trg,  // trigger mask
  input  logic                      cfg_con,  // continuous
  input  logic                      cfg_aut,  // automatic trigger
  input  logic [CW-1:0]             cfg_pst,  // post trigger length
  // controls
  input  logic                      ctl_acq,  // start
  input  logic                      ctl_trg,  // software trigger
  input  logic                      ctl_stp,  // stop
  // output stream
  output acq_pkg::str_t             o_str,
  output logic                      o_vld,
  input  logic                      o_rdy,
  // interrupts
  output logic                      irq_trg,
  output logic                      irq_stp,
  // status
  output logic [CW-1:0]             sts_pre,
  output logic [CW-1:0]             sts_pst,
  output logic                      sts_acq,
  output logic                      sts_trg,
  // time stamps
  output logic [TW-1:0]             cts_acq,
  output logic [TW-1:0]             cts_trg,
  output logic [TW-1:0]             cts_stp
);

import acq_pkg::*;

////////////////////////////////////////////////////////////////////////////
// input handshake
////////////////////////////////////////////////////////////////////////////

acq_state_t acq_st;  // controller state
logic       acq_act;  // pre or post
logic       fwd;      // beat goes to output stage

assign s_rdy = o_rdy | ~o_vld;  // room downstream or empty register
assign s_trn = s_vld & s_rdy;

assign acq_act = (acq_st != ACQ_IDLE);
assign sts_acq = acq_act;
assign fwd     = s_trn & acq_act;  // idle transfers are dropped

////////////////////////////////////////////////////////////////////////////
// trigger and stop events
////////////////////////////////////////////////////////////////////////////

logic [TRG_N-1:0] trg_src;  // raw sources before mask
logic             trg;
logic             stp;
logic [CW-1:0]    pst_nxt;  // post count incl. current beat

always_comb begin
  trg_src          = '0;
  trg_src[TRG_SW]  = ctl_trg;
  trg_src[TRG_LVL] = lvl_trg;
end

// trigger only counts while armed
assign trg = (acq_st == ACQ_PRE) & |(trg_src & cfg_trg);

assign pst_nxt = sts_pst + 1'b1;

// any stop reason, only while acquiring
assign stp = acq_act & (ctl_stp
                     | (s_trn & s_str.lst)
                     | (~cfg_con & (acq_st == ACQ_PST) & s_trn
                        & (pst_nxt == cfg_pst)));

////////////////////////////////////////////////////////////////////////////
// state machine, counters, time stamps
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge sti) begin
  if (ctl_rst) begin
    acq_st  <= ACQ_IDLE;
    sts_trg <= 1'b0;
    sts_pre <= '0;
    sts_pst <= '0;
    cts_acq <= '0;
    cts_trg <= '0;
    cts_stp <= '0;
    irq_trg <= 1'b0;
    irq_stp <= 1'b0;
  end else begin
    irq_trg <= trg;  // one cycle pulses
    irq_stp <= stp;
    case (acq_st)
      ACQ_IDLE: begin
        if (ctl_acq) begin
          acq_st  <= cfg_aut ? ACQ_PST : ACQ_PRE;
          sts_trg <= cfg_aut;
          sts_pre <= '0;
          sts_pst <= '0;
          cts_acq <= cts;
          if (cfg_aut) cts_trg <= cts;  // auto: trigger at start
        end
      end
      ACQ_PRE: begin
        if (s_trn) sts_pre <= sts_pre + 1'b1;  // trigger beat included
        if (trg) begin
          acq_st  <= ACQ_PST;
          sts_trg <= 1'b1;
          cts_trg <= cts;
        end
      end
      ACQ_PST: begin
        if (s_trn) sts_pst <= pst_nxt;
      end
      default: acq_st <= ACQ_IDLE;
    endcase
    // stop overrides whatever the case picked
    if (stp) begin
      acq_st  <= ACQ_IDLE;
      cts_stp <= cts;
    end
  end
end

////////////////////////////////////////////////////////////////////////////
// output register
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge sti) begin
  if (ctl_rst) begin
    o_vld <= 1'b0;
  end else if (s_rdy) begin
    o_vld <= fwd;  // load or drain
  end
end

always_ff @(posedge sti) begin
  if (fwd) begin
    o_str.dat <= s_str.dat;
    o_str.lst <= stp;  // mark the stopping beat
  end
end

endmodule: scope_acq

// File: scope_fifo.sv
`timescale 1ns/100ps

module scope_fifo #(
  int unsigned AW = 4  // address width
)(
  input  logic          sti,      // sample clock
  input  logic          ctl_rst,  // sync reset
  // write side
  input  acq_pkg::str_t w_str,
  input  logic          w_vld,
  output logic          w_rdy,
  // read side
  output acq_pkg::str_t r_str,
  output logic          r_vld,
  input  logic          r_rdy
);

import acq_pkg::*;

localparam int unsigned DEPTH = 2**AW;

////////////////////////////////////////////////////////////////////////////
// storage and pointers
////////////////////////////////////////////////////////////////////////////

str_t          mem [0:DEPTH-1];
logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [AW:0]   cnt;     // entries in mem, not counting r_str

logic w_trn;   // write transfer
logic r_ld;    // output register can take a word
logic mem_rd;  // pop from mem into r_str
logic byp;     // write goes straight to r_str
logic mem_wr;  // push into mem

assign w_rdy  = ~cnt[AW];  // msb set only when full
assign w_trn  = w_vld & w_rdy;
assign r_ld   = ~r_vld | r_rdy;
assign mem_rd = r_ld & (cnt != '0);
assign byp    = r_ld & (cnt == '0) & w_trn;  // empty, keep one cycle latency
assign mem_wr = w_trn & ~byp;

always_ff @(posedge sti) begin
  if (ctl_rst) begin
    wr_ptr <= '0;
    rd_ptr <= '0;
    cnt    <= '0;
  end else begin
    if (mem_wr) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
    if (mem_rd) rd_ptr <= rd_ptr + 1'b1;
    case ({mem_wr, mem_rd})
      2'b10:   cnt <= cnt + 1'b1;
      2'b01:   cnt <= cnt - 1'b1;
      default: cnt <= cnt;  // both or neither
    endcase
  end
end

always_ff @(posedge sti) begin
  if (mem_wr) mem[wr_ptr] <= w_str;
end

////////////////////////////////////////////////////////////////////////////
// registered read port
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge sti) begin
  if (ctl_rst) begin
    r_vld <= 1'b0;
  end else if (r_ld) begin
    r_vld <= mem_rd | byp;
  end
end

always_ff @(posedge sti) begin
  if (mem_rd) r_str <= mem[rd_ptr];  // oldest first
  else if (byp) r_str <= w_str;
end

endmodule: scope_fifo

// File: scope_tb.sv
`timescale 1ns/100ps

module scope_tb;

import acq_pkg::*;

localparam int unsigned TW      = 32;
localparam int unsigned CW      = 16;
localparam int unsigned FIFO_AW = 4;
localparam int BEAT_TMO = 500;   // cycles one input beat may stall
localparam int WAIT_TMO = 4000;  // cycles for any drain wait
localparam int END_STP  = 1;     // trace end codes, 0 is post count
localparam int END_LST  = 2;
localparam int END_RST  = 3;

////////////////////////////////////////////////////////////////////////////
// dut signals
////////////////////////////////////////////////////////////////////////////

logic             sti = 1'b0;
logic             ctl_rst;
logic [TW-1:0]    cts = '0;  // free running time
str_t             s_str;
logic             s_vld;
logic             s_rdy;
str_t             m_str;
logic             m_vld;
logic             m_rdy = 1'b1;
logic [TRG_N-1:0] cfg_trg;
logic             cfg_con;
logic             cfg_aut;
logic [CW-1:0]    cfg_pst;
smp_t             cfg_lvl;
trg_edge_t        cfg_edg;
logic             ctl_acq;
logic             ctl_trg;
logic             ctl_stp;
logic             irq_trg;
logic             irq_stp;
logic [CW-1:0]    sts_pre;
logic [CW-1:0]    sts_pst;
logic             sts_acq;
logic             sts_trg;
logic [TW-1:0]    cts_acq;
logic [TW-1:0]    cts_trg;
logic [TW-1:0]    cts_stp;

scope_top #(.TW (TW), .CW (CW), .FIFO_AW (FIFO_AW)) DUT (
  .sti (sti), .ctl_rst (ctl_rst), .cts (cts),
  .s_str (s_str), .s_vld (s_vld), .s_rdy (s_rdy),
  .m_str (m_str), .m_vld (m_vld), .m_rdy (m_rdy),
  .cfg_trg (cfg_trg), .cfg_con (cfg_con), .cfg_aut (cfg_aut),
  .cfg_pst (cfg_pst), .cfg_lvl (cfg_lvl), .cfg_edg (cfg_edg),
  .ctl_acq (ctl_acq), .ctl_trg (ctl_trg), .ctl_stp (ctl_stp),
  .irq_trg (irq_trg), .irq_stp (irq_stp),
  .sts_pre (sts_pre), .sts_pst (sts_pst), .sts_acq (sts_acq), .sts_trg (sts_trg),
  .cts_acq (cts_acq), .cts_trg (cts_trg), .cts_stp (cts_stp)
);

////////////////////////////////////////////////////////////////////////////
// clock, time base, sink, irq counters
////////////////////////////////////////////////////////////////////////////

integer seed = 26;  // sink back-pressure
int     rnd;
logic   bp_on;      // random m_rdy for this record
str_t   rcv_q[$];   // every beat the sink took
int     n_itrg = 0;
int     n_istp = 0;

always #50 sti = ~sti;  // 100 ns period

always @(posedge sti) cts <= cts + 1'b1;

always @(posedge sti) begin
  rnd = $random(seed);
  m_rdy <= bp_on ? rnd[0] : 1'b1;
  if (!ctl_rst && m_vld && m_rdy) rcv_q.push_back(m_str);  // beat taken at this edge
end

always @(posedge sti) begin
  if (irq_trg) n_itrg <= n_itrg + 1;
  if (irq_stp) n_istp <= n_istp + 1;
end

////////////////////////////////////////////////////////////////////////////
// trace record fields
////////////////////////////////////////////////////////////////////////////

string t_name;
int    t_mask;
int    t_con;
int    t_aut;
int    t_pst;
int    t_lvl;
int    t_edg;
int    t_start;   // ramp start value
int    t_step;    // ramp increment per beat
int    t_n;       // input beats
int    t_trg_idx; // ctl_trg beat, -1 none
int    t_end;
int    t_bp;
int    x_pre;     // expected results
int    x_out;
int    x_itrg;
int    x_istp;

logic [TW-1:0] ts_acq;  // time at the start edge
logic [TW-1:0] ts_trg;  // time at the trigger beat edge
logic [TW-1:0] ts_stp;  // time at the last window beat edge

task automatic abort_run(input string why);
  $display("%s", why);
  $display("TESTS FAILED");
  $fatal(1, "simulation stopped");
endtask

task automatic check_smp(input string what, input smp_t exp, input smp_t act);
  if (act !== exp)
    abort_run($sformatf("Fail %s %s: expected %0d, actual %0d", t_name, what, exp, act));
endtask

task automatic check_cnt(input string what, input logic [CW-1:0] exp,
                         input logic [CW-1:0] act);
  if (act !== exp)
    abort_run($sformatf("Fail %s %s: expected %0d, actual %0d", t_name, what, exp, act));
endtask

task automatic check_ts(input string what, input logic [TW-1:0] exp,
                        input logic [TW-1:0] act);
  if (act !== exp)
    abort_run($sformatf("Fail %s %s: expected %0d, actual %0d", t_name, what, exp, act));
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
  if (act !== exp)
    abort_run($sformatf("Fail %s %s: expected %0b, actual %0b", t_name, what, exp, act));
endtask

// beat i of the record's ramp
function automatic smp_t ramp(input int i);
  return smp_t'(t_start + t_step * i);
endfunction

////////////////////////////////////////////////////////////////////////////
// stimulus and waits
////////////////////////////////////////////////////////////////////////////

task automatic present(input int i);
  s_vld        <= 1'b1;
  s_str.dat    <= ramp(i);
  s_str.lst    <= (t_end == END_LST) && (i == t_n - 1);  // frame end on last beat
  ctl_trg      <= (i == t_trg_idx);
  ctl_stp      <= (t_end == END_STP) && (i == t_n - 1);
endtask

task automatic send_ramp();
  int sent;
  int stall;
  sent  = 0;
  stall = 0;
  present(0);
  while (sent < t_n) begin
    @(posedge sti);
    ctl_trg <= 1'b0;  // controls are single cycle
    ctl_stp <= 1'b0;
    if (s_rdy) begin
      sent++;
      stall = 0;
      if (sent == x_pre) ts_trg = cts;  // trigger beat taken here
      if (sent == x_out) ts_stp = cts;  // stopping beat taken here
      if (sent < t_n) present(sent);
      else s_vld <= 1'b0;
    end else begin
      stall++;
      if (stall > BEAT_TMO)
        abort_run($sformatf("%s: input beat %0d was never accepted", t_name, sent));
    end
  end
endtask

task automatic wait_stop();
  int cyc;
  cyc = 0;
  while (sts_acq) begin
    @(posedge sti);
    cyc++;
    if (cyc > WAIT_TMO) abort_run($sformatf("%s: acquisition never stopped", t_name));
  end
endtask

task automatic wait_outputs(input int base);
  int cyc;
  cyc = 0;
  while (rcv_q.size() - base < x_out) begin
    @(posedge sti);
    cyc++;
    if (cyc > WAIT_TMO)
      abort_run($sformatf("%s: only %0d of %0d output beats arrived", t_name,
                          rcv_q.size() - base, x_out));
  end
endtask

// output side quiet, fifo and output register empty
task automatic wait_quiet();
  int cyc;
  int low;
  cyc = 0;
  low = 0;
  while (low < 3) begin
    @(posedge sti);
    low = m_vld ? 0 : low + 1;
    cyc++;
    if (cyc > WAIT_TMO) abort_run($sformatf("%s: output stream never went idle", t_name));
  end
endtask

task automatic reset_mid();
  check_bit("sts_acq before reset", 1'b1, sts_acq);
  @(posedge sti);
  ctl_rst <= 1'b1;
  repeat (2) @(posedge sti);  // reset seen on one edge, read after the next
  check_bit("m_vld", 1'b0, m_vld);
  check_bit("sts_acq", 1'b0, sts_acq);
  check_bit("sts_trg", 1'b0, sts_trg);
  check_bit("irq_trg", 1'b0, irq_trg);
  check_bit("irq_stp", 1'b0, irq_stp);
  check_cnt("sts_pre", '0, sts_pre);
  check_cnt("sts_pst", '0, sts_pst);
  check_ts("cts_acq", '0, cts_acq);
  check_ts("cts_trg", '0, cts_trg);
  check_ts("cts_stp", '0, cts_stp);
  ctl_rst <= 1'b0;
endtask

task automatic run_test();
  int base;
  int itrg0;
  int istp0;
  int j;
  @(posedge sti);
  cfg_trg <= t_mask[TRG_N-1:0];
  cfg_con <= t_con[0];
  cfg_aut <= t_aut[0];
  cfg_pst <= t_pst[CW-1:0];
  cfg_lvl <= smp_t'(t_lvl);
  cfg_edg <= t_edg[0] ? EDGE_FALL : EDGE_RISE;
  bp_on   <= t_bp[0];
  base  = rcv_q.size();
  itrg0 = n_itrg;
  istp0 = n_istp;
  @(posedge sti);
  ctl_acq <= 1'b1;  // start while s_vld is low
  @(posedge sti);
  ctl_acq <= 1'b0;
  ts_acq = cts;  // start taken at this edge
  ts_trg = cts;  // auto trigger fires at start
  send_ramp();
  if (t_end == END_RST) begin
    reset_mid();
  end else begin
    wait_stop();
    wait_outputs(base);
    wait_quiet();
    check_cnt("output count", CW'(x_out), CW'(rcv_q.size() - base));
    for (j = 0; j < x_out; j++) begin
      check_smp($sformatf("sample %0d", j), ramp(j), rcv_q[base + j].dat);
      check_bit($sformatf("lst of beat %0d", j), j == x_out - 1, rcv_q[base + j].lst);
    end
    check_cnt("sts_pre", CW'(x_pre), sts_pre);
    check_cnt("sts_pst", CW'(x_out - x_pre), sts_pst);  // beats after the trigger beat
    check_bit("sts_acq", 1'b0, sts_acq);
    check_bit("sts_trg", 1'b1, sts_trg);
    check_cnt("irq_trg pulses", CW'(x_itrg), CW'(n_itrg - itrg0));
    check_cnt("irq_stp pulses", CW'(x_istp), CW'(n_istp - istp0));
    check_ts("cts_acq", ts_acq, cts_acq);
    check_ts("cts_trg", ts_trg, cts_trg);
    check_ts("cts_stp", ts_stp, cts_stp);
  end
endtask

////////////////////////////////////////////////////////////////////////////
// main sequence
////////////////////////////////////////////////////////////////////////////

int    fd;
int    rc;
int    n_tests;
string line;

initial begin
  ctl_rst <= 1'b1;
  s_str   <= '0;
  s_vld   <= 1'b0;
  cfg_trg <= '0;
  cfg_con <= 1'b0;
  cfg_aut <= 1'b0;
  cfg_pst <= '0;
  cfg_lvl <= '0;
  cfg_edg <= EDGE_RISE;
  ctl_acq <= 1'b0;
  ctl_trg <= 1'b0;
  ctl_stp <= 1'b0;
  bp_on   <= 1'b0;
  n_tests = 0;
  repeat (8) @(posedge sti);
  ctl_rst <= 1'b0;
  fd = $fopen("scope_trace.txt", "r");
  if (fd == 0) abort_run("could not open scope_trace.txt");
  while (!$feof(fd)) begin
    rc = $fgets(line, fd);
    if (rc > 1 && line.getc(0) != "#") begin  // skip comments and blank lines
      rc = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                   t_name, t_mask, t_con, t_aut, t_pst, t_lvl, t_edg, t_start, t_step,
                   t_n, t_trg_idx, t_end, t_bp, x_pre, x_out, x_itrg, x_istp);
      if (rc != 17) abort_run($sformatf("malformed trace record: %s", line));
      n_tests++;
      run_test();
    end
  end
  $fclose(fd);
  if (n_tests == 0) begin
    abort_run("trace file holds no test records");
  end else begin
    $display("TESTS PASSED");
    $finish;
  end
end

endmodule: scope_tb

// File: scope_top.sv
`timescale 1ns/100ps

module scope_top #(
  int unsigned TW      = 32,  // time stamp width
  int unsigned CW      = 16,  // counter width
  int unsigned FIFO_AW = 4    // fifo address width
)(
  input  logic                      sti,      // sample clock
  input  logic                      ctl_rst,  // sync reset / clear acq
  input  logic [TW-1:0]             cts,      // free running time
  // adc stream in
  input  acq_pkg::str_t             s_str,
  input  logic                      s_vld,
  output logic                      s_rdy,
  // buffered stream out
  output acq_pkg::str_t             m_str,
  output logic                      m_vld,
  input  logic                      m_rdy,
  // configuration
  input  logic [acq_pkg::TRG_N-1:0] cfg_trg,  // trigger mask
  input  logic                      cfg_con,  // continuous
  input  logic                      cfg_aut,  // automatic
  input  logic [CW-1:0]             cfg_pst,  // post length
  input  acq_pkg::smp_t             cfg_lvl,  // level threshold
  input  acq_pkg::trg_edge_t        cfg_edg,  // slope
  // controls
  input  logic                      ctl_acq,
  input  logic                      ctl_trg,
  input  logic                      ctl_stp,
  // interrupts
  output logic                      irq_trg,
  output logic                      irq_stp,
  // status
  output logic [CW-1:0]             sts_pre,
  output logic [CW-1:0]             sts_pst,
  output logic                      sts_acq,
  output logic                      sts_trg,
  // time stamps
  output logic [TW-1:0]             cts_acq,
  output logic [TW-1:0]             cts_trg,
  output logic [TW-1:0]             cts_stp
);

import acq_pkg::*;

logic s_trn;    // input transfer, shared with trigger
logic lvl_trg;  // level crossing pulse
str_t acq_str;  // acq -> fifo
logic acq_vld;
logic acq_rdy;

////////////////////////////////////////////////////////////////////////////
// trigger, controller, buffer
////////////////////////////////////////////////////////////////////////////

scope_trigger u_trg (
  .sti (sti), .ctl_rst (ctl_rst), .str_dat (s_str.dat), .str_trn (s_trn),
  .cfg_lvl (cfg_lvl), .cfg_edg (cfg_edg), .lvl_trg (lvl_trg)
);

scope_acq #(.TW (TW), .CW (CW)) u_acq (
  .sti (sti), .ctl_rst (ctl_rst),
  .s_str (s_str), .s_vld (s_vld), .s_rdy (s_rdy), .s_trn (s_trn), .cts (cts),
  .lvl_trg (lvl_trg), .cfg_trg (cfg_trg), .cfg_con (cfg_con),
  .cfg_aut (cfg_aut), .cfg_pst (cfg_pst),
  .ctl_acq (ctl_acq), .ctl_trg (ctl_trg), .ctl_stp (ctl_stp),
  .o_str (acq_str), .o_vld (acq_vld), .o_rdy (acq_rdy),
  .irq_trg (irq_trg), .irq_stp (irq_stp),
  .sts_pre (sts_pre), .sts_pst (sts_pst), .sts_acq (sts_acq), .sts_trg (sts_trg),
  .cts_acq (cts_acq), .cts_trg (cts_trg), .cts_stp (cts_stp)
);

// back-pressure from m_rdy reaches s_rdy through here
scope_fifo #(.AW (FIFO_AW)) u_fifo (
  .sti (sti), .ctl_rst (ctl_rst),
  .w_str (acq_str), .w_vld (acq_vld), .w_rdy (acq_rdy),
  .r_str (m_str), .r_vld (m_vld), .r_rdy (m_rdy)
);

endmodule: scope_top

// File: scope_trace.txt
# name mask con aut pst lvl edg start step n trg_idx end bp exp_pre exp_out exp_irq_trg exp_irq_stp
# end: 0 post count, 1 ctl_stp on last beat, 2 lst on last beat, 3 reset mid acquisition
auto_basic      0 0 1  12     0 0   100    3 16 -1 0 0  0 12 0 1
# level crossing, rising then falling slope
lvl_rise        2 0 0   8   500 0  -200   50 30 -1 0 0 15 23 1 1
lvl_fall        2 0 0  10  -300 1  1000  -70 36 -1 0 0 20 30 1 1
# level source masked, software trigger on beat 20
sw_masked       1 0 0   6     0 0  -400   40 32 20 0 0 21 27 1 1
# continuous, ended by input lst and by ctl_stp
cont_lst        2 1 0   4  2000 0  1000  100 25 -1 2 0 11 25 1 1
cont_stp        0 1 1   3     0 0 -1000    7 20 -1 1 0  0 20 0 1
# random sink back-pressure
bp_rise         2 0 0  40   100 0  -500   25 70 -1 0 1 25 65 1 1
bp_auto         0 0 1  50     0 0  3000  -11 60 -1 0 1  0 50 0 1
# reset while acquiring, then a plain auto run
rst_mid         0 0 1 200     0 0     0    5 12 -1 3 1  0  0 0 0
auto_after_rst  0 0 1   9     0 0   -50   13 12 -1 0 0  0  9 0 1

// File: scope_trigger.sv
`timescale 1ns/100ps

module scope_trigger (
  input  logic               sti,      // sample clock
  input  logic               ctl_rst,  // sync reset
  // observed input stream
  input  acq_pkg::smp_t      str_dat,  // current sample
  input  logic               str_trn,  // transfer strobe
  // configuration
  input  acq_pkg::smp_t      cfg_lvl,  // threshold
  input  acq_pkg::trg_edge_t cfg_edg,  // slope select
  // crossing pulse
  output logic               lvl_trg
);

import acq_pkg::*;

////////////////////////////////////////////////////////////////////////////
// previous transferred sample
////////////////////////////////////////////////////////////////////////////

smp_t prv_dat;  // last sample seen on a transfer
logic prv_vld;  // prv_dat holds a real sample

// valid flag only, cleared until the first transfer
always_ff @(posedge sti) begin
  if (ctl_rst) begin
    prv_vld <= 1'b0;
  end else if (str_trn) begin
    prv_vld <= 1'b1;
  end
end

always_ff @(posedge sti) begin
  if (str_trn) prv_dat <= str_dat;  // follow every transfer
end

////////////////////////////////////////////////////////////////////////////
// level compare
////////////////////////////////////////////////////////////////////////////

logic crs;  // crossing for selected slope

always_comb begin
  case (cfg_edg)
    // rising: was below, now at or above
    EDGE_RISE: crs = (prv_dat < cfg_lvl) & (str_dat >= cfg_lvl);
    // falling mirrors it
    EDGE_FALL: crs = (prv_dat > cfg_lvl) & (str_dat <= cfg_lvl);
    default:   crs = 1'b0;
  endcase
end

// single cycle pulse, same cycle as the crossing transfer
assign lvl_trg = str_trn & prv_vld & crs;

endmodule: scope_trigger

// File: verilog.f
acq_pkg.sv
scope_trigger.sv
scope_acq.sv
scope_fifo.sv
scope_top.sv
scope_tb.sv
